/* bayerWindow.sv */
`timescale 1ns/1ps
`default_nettype none

module bayerWindow #(
	parameter int frameWidth  = 320,
	parameter int frameHeight = 240
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    advance,
	input  streamPkg::pixelBeat_t   head,
	input  logic                    headValid,
	output pixelPkg::bayerWindow_t  window,
	output logic                    windowValid,
	output logic                    lastPixel
);
	import pixelPkg::*;

	localparam int xWidth = (frameWidth > 1) ? $clog2(frameWidth) : 1;
	localparam int yWidth = (frameHeight > 1) ? $clog2(frameHeight) : 1;

	bayerSample_t      lineBuf [frameWidth];	// Previous row, indexed by column
	bayerSample_t      leftSample;
	bayerSample_t      aboveLeftSample;
	bayerSample_t      aboveSample;
	logic [xWidth-1:0] x;
	logic [yWidth-1:0] y;
	logic [xWidth-1:0] curX;
	logic [yWidth-1:0] curY;
	logic              accept;
	logic              lastCol;
	logic              lastRow;

	assign accept = advance && headValid;

	// A start-of-frame beat is pixel (0,0) whatever the counters say
	assign curX = head.startOfFrame ? '0 : x;
	assign curY = head.startOfFrame ? '0 : y;

	assign lastCol = (curX == xWidth'(frameWidth - 1));
	assign lastRow = (curY == yWidth'(frameHeight - 1));

	// Before the slot is overwritten it still holds the sample one row up
	assign aboveSample = lineBuf[curX];

	always_ff @(posedge clk) begin
		if (accept) begin
			lineBuf[curX]   <= head.sample;
			leftSample      <= head.sample;
			aboveLeftSample <= aboveSample;

			window.current   <= head.sample;
			window.left      <= leftSample;
			window.above     <= aboveSample;
			window.aboveLeft <= aboveLeftSample;
			window.rowOdd    <= curY[0];
			window.colOdd    <= curX[0];
		end
	end

	// At column 0 the left registers still hold the previous row's last
	// pixel, which is harmless because that window is never marked valid
	always_ff @(posedge clk) begin
		if (reset) begin
			x           <= '0;
			y           <= '0;
			windowValid <= 1'b0;
			lastPixel   <= 1'b0;
		end else if (advance) begin
			windowValid <= accept && (curX != '0) && (curY != '0);	// Margins are dropped
			lastPixel   <= accept && lastCol && lastRow;
			if (accept) begin
				if (lastCol) begin
					x <= '0;
					y <= lastRow ? '0 : curY + 1'b1;
				end else begin
					x <= curX + 1'b1;
					y <= curY;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* creditEgress.sv */
`timescale 1ns/1ps
`default_nettype none

module creditEgress #(
	parameter int outputCredits = 4
) (
	input  logic                clk,
	input  logic                reset,
	input  streamPkg::rgbBeat_t rgb,
	input  logic                rgbValid,
	input  logic                outCredit,
	output streamPkg::rgbBeat_t outBeat,
	output logic                outValid,
	output logic                advance
);
	import streamPkg::*;

	logic                   full;	// Output register holds a beat not yet sent
	logic                   send;
	logic [creditWidth-1:0] creditCount;

	// A held beat goes out as soon as downstream has room for it
	assign send     = full && (creditCount != '0);
	assign outValid = send;

	// The register is free next cycle if it is empty now or leaves now,
	// and that is the moment every earlier stage may move one step
	assign advance = !full || send;

	always_ff @(posedge clk) begin
		if (reset) begin
			full        <= 1'b0;
			creditCount <= creditWidth'(outputCredits);
		end else begin
			if (advance) begin
				full <= rgbValid;
			end
			// A returned credit and a send in one cycle cancel out
			creditCount <= creditCount + creditWidth'(outCredit) - creditWidth'(send);
		end
	end

	// With no credits the register keeps its beat and advance stays low,
	// so the whole pipeline holds and the ingress FIFO absorbs new input
	always_ff @(posedge clk) begin
		if (advance && rgbValid) begin
			outBeat <= rgb;
		end
	end

endmodule

`default_nettype wire

/* demosaicStage.sv */
`timescale 1ns/1ps
`default_nettype none

module demosaicStage (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   advance,
	input  pixelPkg::bayerWindow_t window,
	input  logic                   windowValid,
	input  logic                   lastPixel,
	output streamPkg::rgbBeat_t    rgb,
	output logic                   rgbValid
);
	import pixelPkg::*;

	rgbPixel_t  pixel;
	logic [8:0] greenSum;	// Ninth bit keeps the carry of the two greens

	// The parities of the current pixel pick which corner is red and which is blue
	// The other two corners are always the greens
	always_comb begin
		case ({window.rowOdd, window.colOdd})
			2'b00: begin
				pixel.red  = window.current;
				pixel.blue = window.aboveLeft;
				greenSum   = {1'b0, window.left} + {1'b0, window.above};
			end
			2'b01: begin
				pixel.red  = window.left;
				pixel.blue = window.above;
				greenSum   = {1'b0, window.current} + {1'b0, window.aboveLeft};
			end
			2'b10: begin
				pixel.red  = window.above;
				pixel.blue = window.left;
				greenSum   = {1'b0, window.current} + {1'b0, window.aboveLeft};
			end
			default: begin
				pixel.red  = window.aboveLeft;
				pixel.blue = window.current;
				greenSum   = {1'b0, window.left} + {1'b0, window.above};
			end
		endcase
		pixel.green = greenSum[8:1];	// Floor of the average
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rgbValid <= 1'b0;
		end else if (advance) begin
			rgbValid <= windowValid;	// A bubble moves forward as a bubble
		end
	end

	// The beat only changes when a real window moves in
	always_ff @(posedge clk) begin
		if (advance && windowValid) begin
			rgb.pixel       <= pixel;
			rgb.lastOfFrame <= lastPixel;
		end
	end

endmodule

`default_nettype wire

/* demosaicTb.sv */
`timescale 1ns/1ps
`default_nettype none

module demosaicTb;
	import pixelPkg::*;
	import streamPkg::*;

	localparam int frameWidth    = 8;
	localparam int frameHeight   = 6;
	localparam int inputDepth    = 4;
	localparam int outputCredits = 2;
	localparam int framePixels   = frameWidth * frameHeight;
	localparam int frameOutputs  = (frameWidth - 1) * (frameHeight - 1);
	localparam int strayCount    = 3;	// Leftover row 0 samples ahead of a new frame
	localparam int timeoutCycles = (5 * framePixels + strayCount) * 4 + 200;	// Five frames in all

	logic       clk;
	logic       reset;
	pixelBeat_t inBeat;
	logic       inValid;
	logic       inCredit;
	rgbBeat_t   outBeat;
	logic       outValid;
	logic       outCredit = 1'b0;

	bayerSample_t frameBuf [frameHeight][frameWidth];	// Frame being sent, row by row
	rgbPixel_t    expPixels[$];
	logic         expLast[$];
	rgbPixel_t    gotPixels[$];
	logic         gotLast[$];
	logic [31:0]  rngState     = 32'd86256;
	string        testName     = "reset";
	logic         stallCredits = 1'b0;	// Downstream holds back its credits while set
	int           beatsIn        = 0;
	int           creditsIn      = 0;
	int           sentCount      = 0;
	int           outsRecv       = 0;
	int           creditsGiven   = 0;
	int           pendingCredits = 0;
	int           expectedTotal  = 0;
	int           checksRun      = 0;
	int           errorCount     = 0;
	int           cycleCount     = 0;

	demosaicTop #(
		.frameWidth   (frameWidth),
		.frameHeight  (frameHeight),
		.inputDepth   (inputDepth),
		.outputCredits(outputCredits)
	) u_demosaicTop (
		.clk      (clk),
		.reset    (reset),
		.inBeat   (inBeat),
		.inValid  (inValid),
		.inCredit (inCredit),
		.outBeat  (outBeat),
		.outValid (outValid),
		.outCredit(outCredit)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Upstream and downstream models see the same edge values as the DUT
	always @(posedge clk) begin
		if (!reset) begin
			if (inValid && (inputDepth - beatsIn + creditsIn) <= 0) begin
				errorCount++;
				$display("Error in %s: an input beat went out with no credit left", testName);
			end
			if (outValid) begin
				if (outputCredits + creditsGiven - outsRecv <= 0) begin
					errorCount++;
					$display("Error in %s: the DUT sent a beat with no output credit", testName);
				end
				gotPixels.push_back(outBeat.pixel);
				gotLast.push_back(outBeat.lastOfFrame);
				outsRecv <= outsRecv + 1;
				pendingCredits++;
			end
			if (inValid) beatsIn <= beatsIn + 1;
			if (inCredit) creditsIn <= creditsIn + 1;
			if (outCredit) creditsGiven <= creditsGiven + 1;
			// Credits go back at once unless a stall holds them
			if (!stallCredits && pendingCredits > 0) begin
				outCredit <= 1'b1;
				pendingCredits--;
			end else begin
				outCredit <= 1'b0;
			end
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] v;
		v = state;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// In RGGB the even-even corner is red and the odd-odd corner is blue
	// The two remaining corners are green
	function automatic rgbPixel_t expectedRgb(input int x, input int y);
		rgbPixel_t px;
		int        greenSum;
		int        cx;
		int        cy;
		px       = '0;
		greenSum = 0;
		for (cy = y - 1; cy <= y; cy++) begin
			for (cx = x - 1; cx <= x; cx++) begin
				if (cx % 2 == 0 && cy % 2 == 0) begin
					px.red = frameBuf[cy][cx];
				end else if (cx % 2 == 1 && cy % 2 == 1) begin
					px.blue = frameBuf[cy][cx];
				end else begin
					greenSum = greenSum + int'(frameBuf[cy][cx]);
				end
			end
		end
		px.green = 8'(greenSum / 2);	// Floor of the average
		return px;
	endfunction

	task automatic checkRgb(input string name, input rgbPixel_t expected,
		input rgbPixel_t actual);
		checksRun++;
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	task automatic checkLast(input string name, input logic expected, input logic actual);
		checksRun++;
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %s lastOfFrame: expected %b, got %b", name, expected, actual);
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		checksRun++;
		if (actual != expected) begin
			errorCount++;
			$display("[FAIL] %s: expected %0d, got %0d", name, expected, actual);
		end
	endtask

	task automatic fillFlat(input bayerSample_t value);
		int x;
		int y;
		for (y = 0; y < frameHeight; y++) begin
			for (x = 0; x < frameWidth; x++) begin
				frameBuf[y][x] = value;
			end
		end
	endtask

	task automatic fillRandom();
		int x;
		int y;
		for (y = 0; y < frameHeight; y++) begin
			for (x = 0; x < frameWidth; x++) begin
				rngState       = xorshift32(rngState);
				frameBuf[y][x] = rngState[7:0];
			end
		end
	endtask

	// Row 0 and column 0 give no output
	task automatic queueExpected();
		int x;
		int y;
		for (y = 1; y < frameHeight; y++) begin
			for (x = 1; x < frameWidth; x++) begin
				expPixels.push_back(expectedRgb(x, y));
				expLast.push_back(x == frameWidth - 1 && y == frameHeight - 1);
			end
		end
		expectedTotal += frameOutputs;
	endtask

	task automatic sendFrame();
		int x;
		int y;
		for (y = 0; y < frameHeight; y++) begin
			for (x = 0; x < frameWidth; x++) begin
				@(posedge clk);
				while (inputDepth - sentCount + creditsIn <= 0) begin
					inValid <= 1'b0;	// Out of credit so upstream waits
					@(posedge clk);
				end
				inBeat.sample       <= frameBuf[y][x];
				inBeat.startOfFrame <= (x == 0 && y == 0);
				inValid             <= 1'b1;
				sentCount++;
			end
		end
	endtask

	// Samples with no frame start move the column counter off zero
	// They land in row 0, so they produce no output
	task automatic sendStraySamples(input int count);
		int i;
		for (i = 0; i < count; i++) begin
			@(posedge clk);
			while (inputDepth - sentCount + creditsIn <= 0) begin
				inValid <= 1'b0;
				@(posedge clk);
			end
			rngState             = xorshift32(rngState);
			inBeat.sample       <= rngState[7:0];
			inBeat.startOfFrame <= 1'b0;
			inValid             <= 1'b1;
			sentCount++;
		end
	endtask

	task automatic idleInput();
		@(posedge clk);
		inValid <= 1'b0;
	endtask

	// Waits for every queued output and for all input credits, then compares in order
	task automatic collectAndCompare(input int count);
		int        i;
		rgbPixel_t wantPix;
		rgbPixel_t gotPix;
		logic      wantLast;
		logic      gotLastBit;
		while (outsRecv < expectedTotal) @(posedge clk);
		while (beatsIn != sentCount || creditsIn < beatsIn) @(posedge clk);
		checkCount({testName, " output count"}, expectedTotal, outsRecv);
		for (i = 0; i < count; i++) begin
			wantPix    = expPixels.pop_front();
			gotPix     = gotPixels.pop_front();
			wantLast   = expLast.pop_front();
			gotLastBit = gotLast.pop_front();
			checkRgb(testName, wantPix, gotPix);
			checkLast(testName, wantLast, gotLastBit);
		end
	endtask

	task automatic resetStateTest();
		int i;
		testName = "reset state";
		for (i = 0; i < 8; i++) begin
			@(posedge clk);
			checkCount({testName, " outValid"}, 0, int'(outValid));
			checkCount({testName, " inCredit"}, 0, int'(inCredit));
		end
		checkCount({testName, " credits"}, inputDepth, inputDepth - beatsIn + creditsIn);
	endtask

	task automatic flatFrameTest();
		testName = "flat frame";
		fillFlat(8'd100);
		queueExpected();
		sendFrame();
		idleInput();
		collectAndCompare(frameOutputs);
	endtask

	task automatic randomFrameTest();
		testName = "random frame";
		fillRandom();
		queueExpected();
		sendFrame();
		idleInput();
		collectAndCompare(frameOutputs);
	endtask

	task automatic backPressureTest();
		int startSent;
		testName  = "back-pressure";
		startSent = sentCount;
		fillRandom();
		queueExpected();
		fork
			begin
				sendFrame();
				idleInput();
			end
			begin
				while (sentCount < startSent + framePixels / 2) @(posedge clk);
				stallCredits <= 1'b1;
				repeat (40) @(posedge clk);
				stallCredits <= 1'b0;
			end
		join
		collectAndCompare(frameOutputs);
	endtask

	task automatic backToBackTest();
		testName = "two frames";
		sendStraySamples(strayCount);	// The first frame must start over at column 0
		fillRandom();
		queueExpected();
		sendFrame();
		fillRandom();	// The next frame follows with no idle cycle
		queueExpected();
		sendFrame();
		idleInput();
		collectAndCompare(2 * frameOutputs);
	endtask

	task automatic creditBalanceTest();
		testName = "credit conservation";
		checkCount({testName, " credits"}, inputDepth, inputDepth - beatsIn + creditsIn);
		checkCount({testName, " returned"}, sentCount, creditsIn);
	endtask

	initial begin
		reset   <= 1'b1;
		inValid <= 1'b0;
		inBeat  <= '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		resetStateTest();
		flatFrameTest();
		randomFrameTest();
		backPressureTest();
		backToBackTest();
		creditBalanceTest();
		$display("Checks run: %0d, errors: %0d", checksRun, errorCount);
		if (errorCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		while (cycleCount < timeoutCycles) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Run hung in %s with no progress after %0d cycles", testName, cycleCount);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* demosaicTop.sv */
`timescale 1ns/1ps
`default_nettype none

module demosaicTop #(
	parameter int frameWidth    = 320,
	parameter int frameHeight   = 240,
	parameter int inputDepth    = 8,
	parameter int outputCredits = 4
) (
	input  logic                  clk,
	input  logic                  reset,
	input  streamPkg::pixelBeat_t inBeat,
	input  logic                  inValid,
	output logic                  inCredit,
	output streamPkg::rgbBeat_t   outBeat,
	output logic                  outValid,
	input  logic                  outCredit
);
	import pixelPkg::*;
	import streamPkg::*;

	pixelBeat_t   head;
	logic         headValid;
	bayerWindow_t window;
	logic         windowValid;
	logic         lastPixel;
	rgbBeat_t     rgb;
	logic         rgbValid;
	logic         advance;	// Common enable, driven from the output end

	pixelIngress #(
		.inputDepth(inputDepth)
	) u_pixelIngress (
		.clk      (clk),
		.reset    (reset),
		.inBeat   (inBeat),
		.inValid  (inValid),
		.inCredit (inCredit),
		.advance  (advance),
		.head     (head),
		.headValid(headValid)
	);

	bayerWindow #(
		.frameWidth (frameWidth),
		.frameHeight(frameHeight)
	) u_bayerWindow (
		.clk        (clk),
		.reset      (reset),
		.advance    (advance),
		.head       (head),
		.headValid  (headValid),
		.window     (window),
		.windowValid(windowValid),
		.lastPixel  (lastPixel)
	);

	demosaicStage u_demosaicStage (
		.clk        (clk),
		.reset      (reset),
		.advance    (advance),
		.window     (window),
		.windowValid(windowValid),
		.lastPixel  (lastPixel),
		.rgb        (rgb),
		.rgbValid   (rgbValid)
	);

	creditEgress #(
		.outputCredits(outputCredits)
	) u_creditEgress (
		.clk      (clk),
		.reset    (reset),
		.rgb      (rgb),
		.rgbValid (rgbValid),
		.outCredit(outCredit),
		.outBeat  (outBeat),
		.outValid (outValid),
		.advance  (advance)
	);

endmodule

`default_nettype wire

/* pixelIngress.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelIngress #(
	parameter int inputDepth = 8
) (
	input  logic                  clk,
	input  logic                  reset,
	input  streamPkg::pixelBeat_t inBeat,
	input  logic                  inValid,
	output logic                  inCredit,
	input  logic                  advance,
	output streamPkg::pixelBeat_t head,
	output logic                  headValid
);
	import streamPkg::*;

	localparam int ptrWidth = (inputDepth > 1) ? $clog2(inputDepth) : 1;

	pixelBeat_t             mem [inputDepth];
	logic [ptrWidth-1:0]    wrPtr;
	logic [ptrWidth-1:0]    rdPtr;
	logic [creditWidth-1:0] fillCount;
	logic                   pop;

	// Pointers wrap at the depth, which need not be a power of two
	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		logic [ptrWidth-1:0] result;
		if (ptr == ptrWidth'(inputDepth - 1)) begin
			result = '0;
		end else begin
			result = ptr + 1'b1;
		end
		return result;
	endfunction

	// The head is read straight from storage, so a beat written at one edge
	// can leave at the next
	assign head      = mem[rdPtr];
	assign headValid = (fillCount != '0);
	assign pop       = advance && headValid;

	// Upstream never sends without a credit, so a write always has room
	always_ff @(posedge clk) begin
		if (inValid) begin
			mem[wrPtr] <= inBeat;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			fillCount <= '0;
			inCredit  <= 1'b0;
		end else begin
			if (inValid) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			fillCount <= fillCount + creditWidth'(inValid) - creditWidth'(pop);
			inCredit  <= pop;	// One credit back for every slot freed
		end
	end

	// The fill count never exceeds inputDepth, so the credit width
	// covers the deepest configuration upstream can ask for

endmodule

`default_nettype wire

/* pixelPkg.sv */
`default_nettype none

// Pixel and color types shared by the window and color stages
package pixelPkg;

	// One raw sensor value of the RGGB mosaic
	typedef logic [7:0] bayerSample_t;

	// Reconstructed color pixel, red in the top byte
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgbPixel_t;

	// The 2x2 neighborhood that ends at the current pixel
	// Rows run top to bottom and columns left to right, so above and left
	// are the earlier samples in raster order
	typedef struct packed {
		bayerSample_t current;
		bayerSample_t left;
		bayerSample_t above;
		bayerSample_t aboveLeft;
		logic         rowOdd;	// Row parity of the current pixel
		logic         colOdd;	// Column parity of the current pixel
	} bayerWindow_t;

	// With RGGB the parities of the current pixel name the window phase
	//   00 current is red, aboveLeft is blue
	//   01 left is red, above is blue
	//   10 above is red, left is blue
	//   11 aboveLeft is red, current is blue

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the demosaic testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module demosaicTb -f sim.f -o demosaicSim

output="$(./obj_dir/demosaicSim)"
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1

/* sim.f */
pixelPkg.sv
streamPkg.sv
pixelIngress.sv
bayerWindow.sv
demosaicStage.sv
creditEgress.sv
demosaicTop.sv
demosaicTb.sv

/* streamPkg.sv */
`default_nettype none

// Transport types for the credited input and output streams
package streamPkg;

	// Width of every credit and fill counter, wide enough for 16 credits
	localparam int creditWidth = 5;

	// Beat on the input stream
	typedef struct packed {
		pixelPkg::bayerSample_t sample;
		logic                   startOfFrame;	// Set on pixel (0,0) of a frame
	} pixelBeat_t;

	// Beat on the output stream
	typedef struct packed {
		pixelPkg::rgbPixel_t pixel;
		logic                lastOfFrame;	// Set on the final output of a frame
	} rgbBeat_t;

	// Both streams move one beat per valid cycle
	// The sender holds a credit for every beat it sends, and the receiver
	// returns one credit per single-cycle pulse once the slot is free again

endpackage

`default_nettype wire
